//--- logic/video_pkg.sv
// ##############################
// Video side types and constants
// Pixel codes, palette words, colour, blanking
// ##############################
`default_nettype none

package video_pkg;

    localparam int SLOTS_PER_PXL = 4;  // Clocks per pixel
    localparam int SLOT_W        = $clog2(SLOTS_PER_PXL);
    localparam int BLANK_DLY     = 3;  // Pixels from input to rgb

    // Slot roles within one pixel
    localparam logic [SLOT_W-1:0] SLOT_RD_LO = 2'd0;
    localparam logic [SLOT_W-1:0] SLOT_RD_HI = 2'd1;

    typedef struct packed {
        logic [1:0] bank;   // Palette bank
        logic       prio;   // Priority flag
        logic [3:0] idx;    // Colour index, 0 is transparent
    } pxl_code_t;

    typedef struct packed {
        pxl_code_t gfx1;
        pxl_code_t gfx2;
    } layer_pair_t;

    typedef struct packed {
        logic lhbl;  // Active low
        logic lvbl;  // Active low
    } blank_t;

    typedef struct packed {
        pxl_code_t code;
        logic      half;  // 0 low byte, 1 high byte
    } pal_addr_t;

    // BGR order so the packed value matches the palette word
    typedef struct packed {
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } rgb_t;

    typedef union packed {
        struct packed {
            logic [7:0] hi_byte;
            logic [7:0] lo_byte;
        } bytes;
        struct packed {
            logic unused;
            rgb_t rgb;
        } col;
    } pal_word_u;

endpackage

`default_nettype wire

//--- logic/cpu_bus_pkg.sv
// ##############################
// CPU palette write bus
// Request format and credit sizing
// ##############################
`default_nettype none

package cpu_bus_pkg;

    localparam int WQ_DEPTH = 4;                  // Entries, also initial credits
    localparam int WQ_AW    = $clog2(WQ_DEPTH);   // Queue pointer width
    localparam int CREDIT_W = 3;                  // Holds 0..WQ_DEPTH

    // One palette write, valid for a single clock
    typedef struct packed {
        logic       valid;
        logic [7:0] addr;
        logic [7:0] data;
    } pal_wr_t;

    // Initial credit count as a sized constant
    localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(WQ_DEPTH);

endpackage

`default_nettype wire

//--- logic/pal_write_queue.sv
// ##############################
// Palette write queue
// Holds CPU writes until the arbiter retires them
// ##############################
`default_nettype none

module pal_write_queue
    import cpu_bus_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire pal_wr_t wr_in,
    input  wire logic    wq_pop,
    output pal_wr_t      head,
    output logic         credit_ret
);

    pal_wr_t              mem [WQ_DEPTH];  // Entry storage
    logic [WQ_AW-1:0]     wr_ptr;
    logic [WQ_AW-1:0]     rd_ptr;
    logic [CREDIT_W-1:0]  count;           // Occupancy
    logic                 push;
    logic                 pop;

    assign push = wr_in.valid;             // Sender only writes with a credit
    assign pop  = wq_pop && head.valid;

    // Head entry as seen by the arbiter
    assign head.valid = count != '0;
    assign head.addr  = mem[rd_ptr].addr;
    assign head.data  = mem[rd_ptr].data;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= pop;             // One credit back per retired entry
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at WQ_DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/layer_prio.sv
// ##############################
// Layer priority
// Picks the visible layer once per pixel
// ##############################
`default_nettype none

module layer_prio
    import video_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        pxl_cen,
    input  wire layer_pair_t layers,
    input  wire blank_t      blank_in,
    output pxl_code_t        code_sel,
    output blank_t           blank_smp
);

    logic      gfx1_clear;   // Layer 1 transparent
    logic      gfx2_wins;
    pxl_code_t code_nx;

    assign gfx1_clear = layers.gfx1.idx == 4'd0;

    // Layer 2 shows through unless layer 1 is opaque and layer 2 has prio set
    assign gfx2_wins  = gfx1_clear || !layers.gfx2.prio;
    assign code_nx    = gfx2_wins ? layers.gfx2 : layers.gfx1;

    // Code is payload, used by the next two read slots
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            code_sel <= code_nx;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            blank_smp <= '0;         // Reads as blanking
        end else if (pxl_cen) begin
            blank_smp <= blank_in;   // Same pixel as code_sel
        end
    end

endmodule

`default_nettype wire

//--- logic/pal_slot_arbiter.sv
// ##############################
// Palette slot arbiter
// Video reads in slots 0-1, CPU writes in 2-3
// ##############################
`default_nettype none

module pal_slot_arbiter
    import video_pkg::*;
    import cpu_bus_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire pxl_code_t   code_sel,
    input  wire pal_wr_t     head,
    output logic             wq_pop,
    output logic             pxl_cen,
    output logic [SLOT_W-1:0] slot,
    output pal_addr_t        ram_addr,
    output logic             ram_we,
    output logic [7:0]       ram_wdata
);

    logic cpu_slot;   // Slots 2 and 3 belong to the CPU

    // Free running slot counter
    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;   // Wraps after slot 3
        end
    end

    assign pxl_cen  = slot == SLOT_W'(SLOTS_PER_PXL - 1);
    assign cpu_slot = slot[SLOT_W-1];

    // Queue head goes out only in a CPU slot
    assign wq_pop    = cpu_slot && head.valid;
    assign ram_we    = wq_pop;
    assign ram_wdata = head.data;

    always_comb begin
        case (slot)
            SLOT_RD_LO: begin
                ram_addr.code = code_sel;
                ram_addr.half = 1'b0;        // Low byte first
            end
            SLOT_RD_HI: begin
                ram_addr.code = code_sel;
                ram_addr.half = 1'b1;
            end
            default: begin
                ram_addr = pal_addr_t'(head.addr);   // CPU byte address
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/pal_ram.sv
// ##############################
// Palette RAM, 256 x 8
// ##############################
`default_nettype none

module pal_ram
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire pal_addr_t  addr,
    input  wire logic       we,
    input  wire logic [7:0] wdata,
    output logic [7:0]      rdata
);

    localparam int DEPTH = 2 ** $bits(pal_addr_t);

    logic [7:0] mem [DEPTH];

    // Single port, write first
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata     <= wdata;   // New byte on the read side
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- logic/colour_out.sv
// ##############################
// Colour output stage
// Byte join, pixel delay and blanking
// ##############################
`default_nettype none

module colour_out
    import video_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              pxl_cen,
    input  wire logic [SLOT_W-1:0] slot,
    input  wire logic [7:0]        rdata,
    input  wire blank_t            blank_smp,
    output rgb_t                   rgb,
    output blank_t                 blank_dly
);

    pal_word_u word;                   // Filled one byte per slot
    rgb_t      rgb_pipe   [BLANK_DLY];
    blank_t    blank_pipe [BLANK_DLY];
    logic      visible;
    rgb_t      rgb_in;

    // RAM data lags the address by one clock
    always_ff @(posedge clk) begin
        if (slot == SLOT_RD_HI) begin
            word.bytes.lo_byte <= rdata;   // Read issued in slot 0
        end
        if (slot == SLOT_RD_HI + 1'b1) begin
            word.bytes.hi_byte <= rdata;   // Read issued in slot 1
        end
    end

    assign visible = blank_smp.lhbl && blank_smp.lvbl;
    assign rgb_in  = visible ? word.col.rgb : '0;   // Black in blanking

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BLANK_DLY; i++) begin
                rgb_pipe[i]   <= '0;
                blank_pipe[i] <= '0;
            end
        end else if (pxl_cen) begin
            rgb_pipe[0]   <= rgb_in;
            blank_pipe[0] <= blank_smp;
            for (int i = 1; i < BLANK_DLY; i++) begin
                rgb_pipe[i]   <= rgb_pipe[i-1];   // One pixel per stage
                blank_pipe[i] <= blank_pipe[i-1];
            end
        end
    end

    assign rgb       = rgb_pipe[BLANK_DLY-1];
    assign blank_dly = blank_pipe[BLANK_DLY-1];

endmodule

`default_nettype wire

//--- logic/colmix_top.sv
// ##############################
// Colour mixer top
// Layer priority, shared palette, colour out
// ##############################
`default_nettype none

module colmix_top
    import video_pkg::*;
    import cpu_bus_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire pal_wr_t     wr_in,
    output logic             credit_ret,
    input  wire layer_pair_t layers,
    input  wire blank_t      blank_in,
    output logic             pxl_cen,
    output rgb_t             rgb,
    output blank_t           blank_dly
);

    pal_wr_t           head;       // Oldest queued write
    logic              wq_pop;
    pxl_code_t         code_sel;   // Winning layer code
    blank_t            blank_smp;
    logic [SLOT_W-1:0] slot;
    pal_addr_t         ram_addr;
    logic              ram_we;
    logic [7:0]        ram_wdata;
    logic [7:0]        ram_rdata;

    pal_write_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .wr_in      (wr_in),
        .wq_pop     (wq_pop),
        .head       (head),
        .credit_ret (credit_ret)
    );

    layer_prio u_prio (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .layers    (layers),
        .blank_in  (blank_in),
        .code_sel  (code_sel),
        .blank_smp (blank_smp)
    );

    pal_slot_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .code_sel  (code_sel),
        .head      (head),
        .wq_pop    (wq_pop),
        .pxl_cen   (pxl_cen),
        .slot      (slot),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata)
    );

    pal_ram u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    colour_out u_out (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .slot      (slot),
        .rdata     (ram_rdata),
        .blank_smp (blank_smp),
        .rgb       (rgb),
        .blank_dly (blank_dly)
    );

endmodule

`default_nettype wire

//--- test/colmix_tb.sv
// ##############################
// Colour mixer testbench
// File driven palette writes and pixel checks
// ##############################
`default_nettype none

module colmix_tb
    import video_pkg::*;
    import cpu_bus_pkg::*;
();

    localparam int WAIT_LIMIT = 400;   // Clocks before any wait gives up

    logic        clk;
    logic        rst;
    pal_wr_t     wr_in;
    logic        credit_ret;
    layer_pair_t layers;
    blank_t      blank_in;
    logic        pxl_cen;
    rgb_t        rgb;
    blank_t      blank_dly;

    int   errors;
    int   checks;
    int   sent_total;              // Writes handed to the DUT
    int   ret_total;               // credit_ret pulses seen
    int   sent_mark;               // Totals at the last sync line
    int   ret_mark;
    int   strobe_gap;              // Clocks since the last pixel strobe
    logic strobe_seen;
    logic timed_out;

    // Pixel on the inputs and not yet sampled by a strobe
    logic        cur_valid;
    logic [14:0] cur_rgb;
    blank_t      cur_blank;
    string       cur_name;

    // One entry per pixel strobe with the oldest first
    logic        tag_valid [$];
    logic [14:0] tag_rgb   [$];
    blank_t      tag_blank [$];
    string       tag_name  [$];

    colmix_top DUT (
        .clk        (clk),
        .rst        (rst),
        .wr_in      (wr_in),
        .credit_ret (credit_ret),
        .layers     (layers),
        .blank_in   (blank_in),
        .pxl_cen    (pxl_cen),
        .rgb        (rgb),
        .blank_dly  (blank_dly)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Credit pulses counted once per clock
    always @(posedge clk) begin
        if (rst) begin
            ret_total <= 0;
        end else if (credit_ret) begin
            ret_total <= ret_total + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // At the strobe clock rgb holds the pixel sampled BLANK_DLY+1 strobes back
    always @(negedge clk) begin
        if (!rst) begin
            strobe_gap++;
        end
        if (!rst && pxl_cen) begin
            if (strobe_seen) begin
                check_value("pixel strobe spacing", 32'(SLOTS_PER_PXL), 32'(strobe_gap));
            end
            strobe_seen = 1'b1;
            strobe_gap  = 0;
            if (tag_valid.size() == BLANK_DLY + 1) begin
                if (tag_valid[0]) begin
                    check_value({tag_name[0], " rgb"}, 32'(tag_rgb[0]), 32'(rgb));
                    check_value({tag_name[0], " blank"}, 32'(tag_blank[0]), 32'(blank_dly));
                end
                tag_valid.delete(0);
                tag_rgb.delete(0);
                tag_blank.delete(0);
                tag_name.delete(0);
            end
            tag_valid.push_back(cur_valid);   // Sampled at the coming edge
            tag_rgb.push_back(cur_rgb);
            tag_blank.push_back(cur_blank);
            tag_name.push_back(cur_name);
            cur_valid = 1'b0;                 // Held inputs are not checked twice
        end
    end

    task automatic wait_strobe();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!pxl_cen && n < WAIT_LIMIT);
        if (!pxl_cen) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: no pixel strobe within %0d clocks", WAIT_LIMIT);
        end
    endtask

    // Presented in slot 0 and held until the next strobe samples it
    task automatic drive_pixel(input logic [6:0] g1, input logic [6:0] g2, input logic h,
                               input logic v, input logic [14:0] exp_rgb, input int line_no);
        wait_strobe();
        @(negedge clk);
        layers.gfx1    = g1;
        layers.gfx2    = g2;
        blank_in.lhbl  = h;
        blank_in.lvbl  = v;
        cur_valid      = sent_total == ret_total;   // Skip while a write is in flight
        cur_rgb        = exp_rgb;
        cur_blank.lhbl = h;
        cur_blank.lvbl = v;
        cur_name       = $sformatf("pixel line %0d", line_no);
    endtask

    task automatic send_write(input logic [7:0] addr, input logic [7:0] data);
        int n;
        repeat ($urandom % 4) @(negedge clk);   // Idle gap of 0 to 3 clocks
        n = 0;
        // Needs a credit and keeps off the strobe clock
        while ((sent_total - ret_total >= int'(CREDIT_INIT) || pxl_cen) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (sent_total - ret_total >= int'(CREDIT_INIT) || pxl_cen) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: no credit came back for the write to %h", addr);
        end else begin
            wr_in.valid = 1'b1;
            wr_in.addr  = addr;
            wr_in.data  = data;
            cur_valid   = 1'b0;   // Unsampled pixel could read either value
            sent_total++;
            @(negedge clk);
            wr_in.valid = 1'b0;   // One clock per write
        end
    endtask

    task automatic wait_credits(input int n_exp);
        int n;
        n = 0;
        while (ret_total < sent_total && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ret_total < sent_total) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: %0d credit pulses missing", sent_total - ret_total);
        end else begin
            check_value("writes since sync", 32'(n_exp), 32'(sent_total - sent_mark));
            check_value("credits since sync", 32'(n_exp), 32'(ret_total - ret_mark));
        end
        sent_mark = sent_total;
        ret_mark  = ret_total;
    endtask

    initial begin
        int               fd;
        int               code;
        int               line_no;
        int               n;
        int               h;
        int               v;
        logic [7:0]       kind;
        logic [7:0]       a;
        logic [7:0]       d;
        logic [6:0]       g1;
        logic [6:0]       g2;
        logic [14:0]      exp_rgb;
        logic [8*120-1:0] rest;

        rst         = 1'b1;
        wr_in       = '0;
        layers      = '0;
        blank_in    = '0;
        cur_valid   = 1'b0;
        cur_rgb     = '0;
        cur_blank   = '0;
        cur_name    = "";
        errors      = 0;
        checks      = 0;
        sent_total  = 0;
        sent_mark   = 0;
        ret_mark    = 0;
        strobe_gap  = 0;
        strobe_seen = 1'b0;
        timed_out   = 1'b0;
        void'($urandom(63));

        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("rgb after reset", 32'd0, 32'(rgb));
        check_value("blank after reset", 32'd0, 32'(blank_dly));
        check_value("credit after reset", 32'd0, 32'(credit_ret));
        rst = 1'b0;

        fd = $fopen("test/colmix_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file");
        end else begin
            line_no = 0;
            code    = $fscanf(fd, " %c", kind);
            while (code == 1 && !timed_out) begin
                line_no++;
                case (kind)
                    "#": code = $fgets(rest, fd);   // Comment line
                    "W": begin
                        code = $fscanf(fd, "%h %h", a, d);
                        send_write(a, d);
                    end
                    "S": begin
                        code = $fscanf(fd, "%d", n);
                        wait_credits(n);
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h %d %d %h", g1, g2, h, v, exp_rgb);
                        drive_pixel(g1, g2, h[0], v[0], exp_rgb, line_no);
                    end
                    default: begin
                        errors++;
                        $display("unknown record on stimulus line %0d", line_no);
                    end
                endcase
                code = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end

        // Flush the pixel delay so the last pixels get checked
        repeat (BLANK_DLY + 3) begin
            if (!timed_out) begin
                wait_strobe();
            end
        end
        @(negedge clk);
        check_value("credit total", 32'(sent_total), 32'(ret_total));

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/colmix_stimulus.txt
# W addr data | S writes since last S | P gfx1 gfx2 lhbl lvbl expected rgb
# Hex values except the S count and the two blank flags
# Burst of eight writes for entries 01 12 23 43
W 02 1F
W 03 00
W 24 E0
W 25 03
W 46 00
W 47 7C
W 86 34
W 87 92
S 8
# Bank 3 entry
W CA CD
W CB 2B
S 2
# Layer 2 shows when layer 1 is transparent
P 10 01 1 1 001F
P 00 12 1 1 03E0
# Layer 1 opaque and layer 2 priority decides
P 23 01 1 1 001F
P 23 12 1 1 7C00
P 33 23 1 1 7C00
P 12 65 1 1 2BCD
# Bank bits pick the region
P 43 12 1 1 1234
P 65 12 1 1 2BCD
# Blanking forces black
P 23 12 0 1 0000
P 23 12 1 0 0000
P 65 12 0 0 0000
P 43 12 1 1 1234
# Entry 01 rewritten while pixels stream
P 01 01 1 1 001F
P 01 01 1 1 001F
W 02 0A
P 01 01 1 1 000A
P 01 01 1 1 000A
P 01 01 1 1 000A
P 10 01 1 1 000A
S 1
P 01 01 1 1 000A

//--- all.f
logic/video_pkg.sv
logic/cpu_bus_pkg.sv
logic/pal_write_queue.sv
logic/layer_prio.sv
logic/pal_slot_arbiter.sv
logic/pal_ram.sv
logic/colour_out.sv
logic/colmix_top.sv
test/colmix_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the colour mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module colmix_tb -f all.f -o colmix_sim \
    && out=$(./obj_dir/colmix_sim) \
    || { echo "Build or simulation run failed"; exit 1; }

echo "$out"

echo "$out" | grep -qx "All tests passed" \
    && exit 0 \
    || exit 1
